// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the compress_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_compress_mem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_compress_mem 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== source/compress_mem_top.sv ====
`timescale 1ns/1ps

module compress_mem_top
    import huff_pkg::*;
    import mem_map_pkg::*;
#(
    parameter int BUSY_CYCLES = 2,
    parameter int DEPTH_WORDS = MEM_WORDS
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [2:0]         phase_i,
    input  logic [7:0]         byte_i,
    input  logic               byte_valid_i,
    output logic               hist_ready_o,
    input  logic               req_i,
    input  logic               acc_i,
    input  logic [7:0]         index_i,
    input  logic [PATH_W-1:0]  wdata_i,
    output logic [PATH_W-1:0]  rdata_o,
    output logic               done_o,
    output logic               clear_done_o
);

    phase_e              phase;
    access_e             acc;
    logic                hist_req;
    access_e             hist_acc;
    logic [7:0]          hist_index;
    logic [COUNT_W-1:0]  hist_wdata;
    logic [COUNT_W-1:0]  hist_rdata;
    logic                hist_done;

    assign phase = phase_e'(phase_i);
    assign acc   = access_e'(acc_i);

    sram_bus_if bus ();

    histogram u_hist (
        .clk, .rst, .phase_i(phase), .byte_i, .byte_valid_i, .hist_ready_o,
        .hist_req_o(hist_req), .hist_acc_o(hist_acc), .hist_index_o(hist_index),
        .hist_wdata_o(hist_wdata), .hist_rdata_i(hist_rdata), .hist_done_i(hist_done)
    );

    sram_interface u_sif (
        .clk, .rst, .phase_i(phase),
        .hist_req_i(hist_req), .hist_acc_i(hist_acc), .hist_index_i(hist_index),
        .hist_wdata_i(hist_wdata), .hist_rdata_o(hist_rdata), .hist_done_o(hist_done),
        .req_i, .acc_i(acc), .index_i, .wdata_i, .rdata_o, .done_o, .clear_done_o,
        .bus(bus.master)
    );

    sram_model #(.BUSY_CYCLES(BUSY_CYCLES), .DEPTH_WORDS(DEPTH_WORDS)) u_sram (
        .clk, .rst, .bus(bus.slave)
    );

endmodule

// ==== source/histogram.sv ====
`timescale 1ns/1ps

module histogram
    import huff_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  phase_e              phase_i,
    input  logic [7:0]          byte_i,
    input  logic                byte_valid_i,
    output logic                hist_ready_o,
    output logic                hist_req_o,
    output access_e             hist_acc_o,
    output logic [7:0]          hist_index_o,
    output logic [COUNT_W-1:0]  hist_wdata_o,
    input  logic [COUNT_W-1:0]  hist_rdata_i,
    input  logic                hist_done_i
);

    typedef enum logic [1:0] {H_IDLE, H_READ, H_WRITE} state_e;

    state_e              state_q;
    logic                req_q;
    logic [7:0]          byte_q;
    logic [COUNT_W-1:0]  count_q;   // old count plus one

    assign hist_ready_o = (state_q == H_IDLE);
    assign hist_req_o   = req_q;
    assign hist_acc_o   = (state_q == H_WRITE) ? ACC_WRITE : ACC_READ;
    assign hist_index_o = byte_q;
    assign hist_wdata_o = count_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state_q <= H_IDLE;
            req_q   <= 1'b0;
        end else begin
            req_q <= 1'b0;   // one-cycle strobe
            case (state_q)
                H_IDLE: begin
                    if (byte_valid_i && phase_i == PH_HIST) begin
                        state_q <= H_READ;
                        req_q   <= 1'b1;
                    end
                end
                H_READ: begin
                    if (hist_done_i) begin
                        state_q <= H_WRITE;
                        req_q   <= 1'b1;
                    end
                end
                H_WRITE: if (hist_done_i) state_q <= H_IDLE;
                default: state_q <= H_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hist_ready_o && byte_valid_i) byte_q <= byte_i;
        if (state_q == H_READ && hist_done_i) count_q <= hist_rdata_i + 1'b1;   // wraps
    end

endmodule

// ==== source/huff_pkg.sv ====
package huff_pkg;

    // controller phase, also selects the active client in the engine
    typedef enum logic [2:0] {
        PH_IDLE  = 3'd0,
        PH_CLEAR = 3'd1,
        PH_HIST  = 3'd2,
        PH_COUNT = 3'd3,
        PH_NODE  = 3'd4,
        PH_PATH  = 3'd5
    } phase_e;

    typedef enum logic {
        ACC_READ  = 1'b0,
        ACC_WRITE = 1'b1
    } access_e;

    // data widths
    localparam int COUNT_W = 32;
    localparam int NODE_W  = 64;
    localparam int PATH_W  = 128;   // widest item, sets client data ports
    localparam int WORD_W  = 32;

endpackage

// ==== source/mem_map_pkg.sv ====
package mem_map_pkg;

    localparam logic [31:0] SRAM_BASE = 32'h3300_0000;   // byte address of word 0

    // histogram, one word per count
    localparam int unsigned HIST_OFFSET = 0;
    localparam int unsigned HIST_WORDS  = 256;

    // tree nodes
    localparam int unsigned NODE_OFFSET = 256;
    localparam int unsigned NODE_WORDS  = 2;

    // codebook paths
    localparam int unsigned PATH_OFFSET = 512;
    localparam int unsigned PATH_WORDS  = 4;

    localparam int unsigned MEM_WORDS = 1536;

endpackage

// ==== source/sram_bus_if.sv ====
`timescale 1ns/1ps

interface sram_bus_if
    import huff_pkg::*;
();

    logic                  wr_en;
    logic                  r_en;
    logic [WORD_W/8-1:0]   select;   // byte lanes
    logic [31:0]           addr;     // byte address
    logic [WORD_W-1:0]     wdata;
    logic [WORD_W-1:0]     rdata;
    logic                  busy;

    modport master (
        output wr_en, r_en, select, addr, wdata,
        input  rdata, busy
    );

    modport slave (
        input  wr_en, r_en, select, addr, wdata,
        output rdata, busy
    );

endinterface

// ==== source/sram_interface.sv ====
`timescale 1ns/1ps

module sram_interface
    import huff_pkg::*;
    import mem_map_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  phase_e              phase_i,
    input  logic                hist_req_i,
    input  access_e             hist_acc_i,
    input  logic [7:0]          hist_index_i,
    input  logic [COUNT_W-1:0]  hist_wdata_i,
    output logic [COUNT_W-1:0]  hist_rdata_o,
    output logic                hist_done_o,
    input  logic                req_i,
    input  access_e             acc_i,
    input  logic [7:0]          index_i,
    input  logic [PATH_W-1:0]   wdata_i,
    output logic [PATH_W-1:0]   rdata_o,
    output logic                done_o,
    output logic                clear_done_o,
    sram_bus_if.master          bus
);

    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT} state_e;
    typedef enum logic [1:0] {CL_HOST, CL_HIST, CL_CLEAR} client_e;

    state_e             state_q;
    client_e            client_q;
    access_e            acc_q;
    phase_e             phase_q;
    logic [7:0]         word_q;
    logic [7:0]         last_q;
    logic [31:0]        base_q;    // first word offset of the item
    logic [PATH_W-1:0]  item_q;    // word 0 sits at the top
    logic               busy_q;

    logic               start_req;
    client_e            start_client;
    access_e            start_acc;
    logic [31:0]        start_base;
    logic [7:0]         start_last;
    logic [PATH_W-1:0]  start_item;

    logic               take;
    logic               issue;
    logic               word_end;
    logic               last_end;
    logic [WORD_W-1:0]  word_in;

    // phase picks client, region and word count
    always_comb begin
        start_req    = 1'b0;
        start_client = CL_HOST;
        start_acc    = acc_i;
        start_base   = HIST_OFFSET + 32'(index_i);
        start_last   = 8'd0;
        start_item   = wdata_i << (PATH_W - COUNT_W);
        case (phase_i)
            PH_CLEAR: begin
                start_req    = (phase_q != PH_CLEAR);   // once on entry
                start_client = CL_CLEAR;
                start_acc    = ACC_WRITE;
                start_base   = HIST_OFFSET;
                start_last   = 8'(HIST_WORDS - 1);
                start_item   = '0;
            end
            PH_HIST: begin
                start_req    = hist_req_i;
                start_client = CL_HIST;
                start_acc    = hist_acc_i;
                start_base   = HIST_OFFSET + 32'(hist_index_i);
                start_item   = {hist_wdata_i, {(PATH_W - COUNT_W){1'b0}}};
            end
            PH_COUNT: begin
                start_req = req_i;
            end
            PH_NODE: begin
                start_req  = req_i;
                start_base = NODE_OFFSET + NODE_WORDS * 32'(index_i);
                start_last = 8'(NODE_WORDS - 1);
                start_item = wdata_i << (PATH_W - NODE_W);
            end
            PH_PATH: begin
                start_req  = req_i;
                start_base = PATH_OFFSET + PATH_WORDS * 32'(index_i);
                start_last = 8'(PATH_WORDS - 1);
                start_item = wdata_i;
            end
            default: ;
        endcase
    end

    assign take     = start_req && (state_q == S_IDLE);
    assign issue    = (state_q == S_ISSUE) && !bus.busy;
    assign word_end = (state_q == S_WAIT) && busy_q && !bus.busy;   // busy falling
    assign last_end = word_end && (word_q == last_q);
    assign word_in  = (acc_q == ACC_READ) ? bus.rdata : '0;

    assign bus.wr_en  = issue && (acc_q == ACC_WRITE);
    assign bus.r_en   = issue && (acc_q == ACC_READ);
    assign bus.select = '1;
    assign bus.addr   = SRAM_BASE + ((base_q + 32'(word_q)) << 2);
    assign bus.wdata  = item_q[PATH_W-1 -: WORD_W];

    assign rdata_o      = item_q;
    assign hist_rdata_o = item_q[COUNT_W-1:0];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state_q      <= S_IDLE;
            client_q     <= CL_HOST;
            acc_q        <= ACC_READ;
            phase_q      <= PH_IDLE;
            word_q       <= '0;
            last_q       <= '0;
            busy_q       <= 1'b0;
            done_o       <= 1'b0;
            hist_done_o  <= 1'b0;
            clear_done_o <= 1'b0;
        end else begin
            phase_q      <= phase_i;
            busy_q       <= bus.busy;
            done_o       <= last_end && (client_q == CL_HOST);
            hist_done_o  <= last_end && (client_q == CL_HIST);
            clear_done_o <= last_end && (client_q == CL_CLEAR);
            case (state_q)
                S_IDLE: begin
                    if (take) begin
                        client_q <= start_client;
                        acc_q    <= start_acc;
                        word_q   <= '0;
                        last_q   <= start_last;
                        state_q  <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (!bus.busy) state_q <= S_WAIT;
                end
                S_WAIT: begin
                    if (word_end) begin
                        if (word_q == last_q) begin
                            state_q <= S_IDLE;
                        end else begin
                            word_q  <= word_q + 8'd1;
                            state_q <= S_ISSUE;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // write data shifts out at the top, read data shifts in at the bottom
    always_ff @(posedge clk) begin
        if (take) begin
            base_q <= start_base;
            item_q <= (start_acc == ACC_WRITE) ? start_item : '0;
        end else if (word_end) begin
            item_q <= {item_q[PATH_W-WORD_W-1:0], word_in};
        end
    end

endmodule

// ==== source/sram_model.sv ====
`timescale 1ns/1ps

module sram_model
    import huff_pkg::*;
    import mem_map_pkg::*;
#(
    parameter int BUSY_CYCLES = 2,
    parameter int DEPTH_WORDS = MEM_WORDS
) (
    input  logic        clk,
    input  logic        rst,
    sram_bus_if.slave   bus
);

    localparam int AW = $clog2(DEPTH_WORDS);
    localparam int CW = $clog2(BUSY_CYCLES + 1);

    logic [WORD_W-1:0]  mem [DEPTH_WORDS];
    logic [CW-1:0]      busy_cnt;
    logic [31:0]        word_addr;
    logic               in_range;
    logic               access;

    assign word_addr = (bus.addr - SRAM_BASE) >> 2;
    assign in_range  = word_addr < 32'(DEPTH_WORDS);
    assign access    = (bus.wr_en || bus.r_en) && (busy_cnt == '0);
    assign bus.busy  = (busy_cnt != '0);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) busy_cnt <= '0;
        else if (access) busy_cnt <= CW'(BUSY_CYCLES);
        else if (busy_cnt != '0) busy_cnt <= busy_cnt - 1'b1;
    end

    // access done at once, busy only paces the master
    always_ff @(posedge clk) begin
        if (access && in_range) begin
            if (bus.wr_en) begin
                for (int b = 0; b < WORD_W / 8; b++) begin
                    if (bus.select[b]) mem[word_addr[AW-1:0]][b*8 +: 8] <= bus.wdata[b*8 +: 8];
                end
            end else begin
                bus.rdata <= mem[word_addr[AW-1:0]];
            end
        end
    end

endmodule

// ==== verif/tb_compress_mem.sv ====
`timescale 1ns/1ps

module tb_compress_mem
    import huff_pkg::*;
    import mem_map_pkg::*;
();

    localparam int BUSY    = 2;
    localparam int N_BYTES = 200;
    localparam int N_NODES = 16;
    localparam int N_PATHS = 12;
    localparam int MARGIN  = 4;
    // word accesses: clear, three count sweeps, byte rmw, node and path write plus read
    localparam int TOTAL_WORDS = 4 * HIST_WORDS + 2 * N_BYTES
                               + 2 * NODE_WORDS * N_NODES + 2 * PATH_WORDS * N_PATHS;
    localparam int TIMEOUT_NS  = TOTAL_WORDS * (BUSY + 2) * MARGIN * 10 + 400;

    logic          clk;
    logic          rst;
    logic [2:0]    phase_i;
    logic [7:0]    byte_i;
    logic          byte_valid_i;
    logic          hist_ready_o;
    logic          req_i;
    logic          acc_i;
    logic [7:0]    index_i;
    logic [127:0]  wdata_i;
    logic [127:0]  rdata_o;
    logic          done_o;
    logic          clear_done_o;

    logic [31:0]   ref_mem [0:MEM_WORDS-1];   // expected memory image
    logic [127:0]  exp_q [$];
    logic          chk_q [$];   // 1 for reads
    logic [127:0]  exp_front;
    logic          chk_front;
    logic [31:0]   lfsr;
    int            clear_pulses;
    logic          used [0:255];
    logic [7:0]    node_idx [0:N_NODES-1];
    logic [7:0]    path_base;
    logic [127:0]  v;

    compress_mem_top #(.BUSY_CYCLES(BUSY), .DEPTH_WORDS(MEM_WORDS)) UUT (
        .clk, .rst, .phase_i, .byte_i, .byte_valid_i, .hist_ready_o,
        .req_i, .acc_i, .index_i, .wdata_i, .rdata_o, .done_o, .clear_done_o
    );

    always #5 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [127:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[126:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    // word 0 of an item holds its top 32 bits
    function automatic logic [127:0] expected_item(input phase_e ph, input logic [7:0] idx);
        int unsigned  w;
        logic [127:0] r;
        r = '0;
        case (ph)
            PH_COUNT: r = {96'b0, ref_mem[HIST_OFFSET + idx]};
            PH_NODE: begin
                w = NODE_OFFSET + NODE_WORDS * idx;
                r = {64'b0, ref_mem[w], ref_mem[w + 1]};
            end
            PH_PATH: begin
                w = PATH_OFFSET + PATH_WORDS * idx;
                r = {ref_mem[w], ref_mem[w + 1], ref_mem[w + 2], ref_mem[w + 3]};
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic image_write(input phase_e ph, input logic [7:0] idx, input logic [127:0] wd);
        int unsigned w;
        case (ph)
            PH_COUNT: ref_mem[HIST_OFFSET + idx] = wd[31:0];
            PH_NODE: begin
                w = NODE_OFFSET + NODE_WORDS * idx;
                ref_mem[w]     = wd[63:32];
                ref_mem[w + 1] = wd[31:0];
            end
            PH_PATH: begin
                w = PATH_OFFSET + PATH_WORDS * idx;
                for (int k = 0; k < 4; k++) ref_mem[w + k] = wd[127 - 32 * k -: 32];
            end
            default: ;
        endcase
    endtask

    // called on a falling edge, returns on the falling edge that sees done_o
    task automatic host_access(input phase_e ph, input logic wr, input logic [7:0] idx,
                               input logic [127:0] wd);
        if (wr) begin
            image_write(ph, idx, wd);
            exp_q.push_back('0);
            chk_q.push_back(1'b0);
        end else begin
            exp_q.push_back(expected_item(ph, idx));
            chk_q.push_back(1'b1);
        end
        req_i   = 1'b1;
        acc_i   = wr;
        index_i = idx;
        wdata_i = wd;
        @(negedge clk);
        req_i = 1'b0;
        while (done_o !== 1'b1) @(negedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b);
        while (hist_ready_o !== 1'b1) @(negedge clk);
        byte_i       = b;
        byte_valid_i = 1'b1;
        ref_mem[HIST_OFFSET + b] = ref_mem[HIST_OFFSET + b] + 32'd1;
        @(negedge clk);
        byte_valid_i = 1'b0;
    endtask

    task automatic read_all_counts();
        for (int i = 0; i < 256; i++) host_access(PH_COUNT, 1'b0, 8'(i), '0);
    endtask

    // compares every read result against its queued expectation
    always @(negedge clk) begin
        if (clear_done_o === 1'b1) clear_pulses++;
        if (done_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("done_o pulsed at %0t with no host request outstanding", $time);
                $display("FAIL: see errors above");
                $fatal(1, "unexpected done");
            end else begin
                exp_front = exp_q.pop_front();
                chk_front = chk_q.pop_front();
                if (chk_front) check_value("rdata_o", rdata_o, exp_front);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, the DUT stopped answering", TIMEOUT_NS);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog");
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        phase_i      = PH_IDLE;
        byte_i       = '0;
        byte_valid_i = 1'b0;
        req_i        = 1'b0;
        acc_i        = 1'b0;
        index_i      = '0;
        wdata_i      = '0;
        lfsr         = 32'hf151;
        clear_pulses = 0;
        for (int i = 0; i < 256; i++) used[i] = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("done_o", 128'(done_o), '0);
        check_value("clear_done_o", 128'(clear_done_o), '0);
        check_value("hist_ready_o", 128'(hist_ready_o), 128'd1);

        phase_i = PH_CLEAR;
        while (clear_pulses == 0) @(negedge clk);
        repeat (20) @(negedge clk);   // a stretched pulse would show up here
        check_value("clear_done_o pulses", 128'(clear_pulses), 128'd1);
        for (int i = 0; i < HIST_WORDS; i++) ref_mem[HIST_OFFSET + i] = '0;
        phase_i = PH_COUNT;
        read_all_counts();

        phase_i = PH_HIST;
        for (int i = 0; i < N_BYTES; i++) begin
            take_bits(8, v);
            send_byte(v[7:0]);
        end
        while (hist_ready_o !== 1'b1) @(negedge clk);
        phase_i = PH_COUNT;
        read_all_counts();

        phase_i = PH_NODE;
        for (int i = 0; i < N_NODES; i++) begin
            take_bits(7, v);
            while (used[v[7:0]]) take_bits(7, v);   // tree holds 128 nodes
            used[v[7:0]] = 1'b1;
            node_idx[i]  = v[7:0];
            take_bits(64, v);
            host_access(PH_NODE, 1'b1, node_idx[i], {64'b0, v[63:0]});
        end
        for (int i = 0; i < N_NODES; i++) host_access(PH_NODE, 1'b0, node_idx[i], '0);

        phase_i = PH_PATH;
        take_bits(8, v);
        path_base = 8'(v[7:0] % (256 - N_PATHS));
        for (int i = 0; i < N_PATHS; i++) begin
            take_bits(128, v);
            host_access(PH_PATH, 1'b1, path_base + 8'(i), v);
        end
        for (int i = 0; i < N_PATHS; i++) host_access(PH_PATH, 1'b0, path_base + 8'(i), '0);

        phase_i = PH_COUNT;
        read_all_counts();   // regions must not overlap
        @(negedge clk);
        check_value("clear_done_o pulses", 128'(clear_pulses), 128'd1);   // none after the clear

        if (exp_q.size() != 0) begin
            $display("%0d host accesses never completed", exp_q.size());
            $display("FAIL: see errors above");
            $fatal(1, "accesses left over");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
source/huff_pkg.sv
source/mem_map_pkg.sv
source/sram_bus_if.sv
source/histogram.sv
source/sram_interface.sv
source/sram_model.sv
source/compress_mem_top.sv
verif/tb_compress_mem.sv
